// ==== cc_defs.svh ====
`ifndef CC_DEFS_SVH
`define CC_DEFS_SVH

// width of the gap, target gap and alpha values
`define CC_RATE_W       32

// pending requests
`define CC_QDEPTH       8

// reset gap in cycles for both current and target
`define CC_RATE_DEFAULT 40

// mark filtering and alpha decay windows, in cycles
`define CC_MIN_MARK_GAP 60
`define CC_ALPHA_QUIET  80

// alpha fixed point: ONE is 1.0, G is the gain (1/16)
`define CC_ALPHA_ONE    256
`define CC_ALPHA_G      16

// recovery event thresholds
`define CC_TIME_THRESH  50
`define CC_BYTE_THRESH  6

// events per stage before moving on
`define CC_F            5

// additive increase step on the target gap
`define CC_RAI          4

`endif

// ==== cc_pkg.sv ====
`default_nettype none

package cc_pkg;

    // request descriptor, 64 bits in total
    typedef struct packed {
        logic        opcode;
        logic [9:0]  qpn;
        logic [31:0] vaddr;
        logic [20:0] len;
    } dreq_t;

    // opcode encodings
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // recovery stage reported by the rate controller
    typedef enum logic [1:0] {
        stage_fast_recovery = 2'd0,
        stage_additive      = 2'd1,
        stage_hyper         = 2'd2
    } cc_stage_t;

endpackage

`default_nettype wire

// ==== req_fifo.sv ====
`include "cc_defs.svh"
`default_nettype none

module req_fifo
    import cc_pkg::*;
#(
    parameter int DEPTH = `CC_QDEPTH
) (
    input  logic  aclk,
    input  logic  aresetn,

    input  logic  s_valid,
    output logic  s_ready,
    input  dreq_t s_data,

    output logic  m_valid,
    input  logic  m_ready,
    output dreq_t m_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dreq_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // a full queue still takes a word when the head leaves in the same cycle
    assign s_ready = (count != CNT_W'(DEPTH)) || m_ready;
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count only moves when exactly one side fires
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcqcn_rate_ctrl.sv ====
`include "cc_defs.svh"
`default_nettype none

module dcqcn_rate_ctrl
    import cc_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  ecn_valid,
    input  logic                  ecn_mark,

    output logic [`CC_RATE_W-1:0] cur_rate,
    output logic [`CC_RATE_W-1:0] target_rate,
    output logic [`CC_RATE_W-1:0] alpha,
    output cc_stage_t             stage
);

    localparam int W       = `CC_RATE_W;
    localparam int GAP_W   = $clog2(`CC_MIN_MARK_GAP + 2);
    localparam int QUIET_W = $clog2(`CC_ALPHA_QUIET);
    localparam int TIME_W  = $clog2(`CC_TIME_THRESH);
    localparam int ACK_W   = $clog2(`CC_BYTE_THRESH);
    localparam int STG_W   = $clog2(`CC_F + 1);

    logic [GAP_W-1:0]   since_cut;
    logic [QUIET_W-1:0] quiet_cnt;
    logic [TIME_W-1:0]  time_cnt;
    logic [ACK_W-1:0]   ack_cnt;
    logic [STG_W-1:0]   t_stage_cnt;
    logic [STG_W-1:0]   b_stage_cnt;
    logic               inc_evt;

    logic               mark_seen;
    logic               mark_cut;
    logic               time_hit;
    logic               ack_hit;

    logic [2*W-1:0]     cut_num;
    logic [2*W-1:0]     cut_quot;
    logic [W-1:0]       cut_den;
    logic [2*W-1:0]     alpha_prod;
    logic [W-1:0]       alpha_decay;
    logic [W-1:0]       alpha_up;
    logic [W-1:0]       rec_target;
    logic [W:0]         avg_sum;

    assign mark_seen = ecn_valid && ecn_mark;
    // since_cut starts at zero, so marks right after reset are not counted
    assign mark_cut  = mark_seen && (since_cut > GAP_W'(`CC_MIN_MARK_GAP));
    assign time_hit  = (time_cnt == TIME_W'(`CC_TIME_THRESH - 1));
    assign ack_hit   = ecn_valid && (ack_cnt == ACK_W'(`CC_BYTE_THRESH - 1));

    // cut: gap * ONE / (ONE - alpha/2)
    assign cut_num  = {{W{1'b0}}, cur_rate} * (2*W)'(`CC_ALPHA_ONE);
    assign cut_den  = W'(`CC_ALPHA_ONE) - (alpha >> 1);
    assign cut_quot = cut_num / {{W{1'b0}}, cut_den};

    // alpha * (1 - g), and (1 - g) * alpha + g on a cut
    assign alpha_prod  = {{W{1'b0}}, alpha} * (2*W)'(`CC_ALPHA_ONE - `CC_ALPHA_G);
    assign alpha_decay = W'(alpha_prod / (2*W)'(`CC_ALPHA_ONE));
    assign alpha_up    = alpha_decay + W'(`CC_ALPHA_G);

    // additive stage grows the target before averaging
    assign rec_target = (stage == stage_additive) ? target_rate + W'(`CC_RAI) : target_rate;
    assign avg_sum    = {1'b0, rec_target} + {1'b0, cur_rate};

    always_comb begin
        if (t_stage_cnt >= STG_W'(`CC_F) && b_stage_cnt >= STG_W'(`CC_F)) begin
            stage = stage_hyper;
        end else if (t_stage_cnt >= STG_W'(`CC_F) || b_stage_cnt >= STG_W'(`CC_F)) begin
            stage = stage_additive;
        end else begin
            stage = stage_fast_recovery;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cur_rate    <= W'(`CC_RATE_DEFAULT);
            target_rate <= W'(`CC_RATE_DEFAULT);
            alpha       <= W'(`CC_ALPHA_ONE);
            since_cut   <= '0;
            quiet_cnt   <= '0;
            time_cnt    <= '0;
            ack_cnt     <= '0;
            t_stage_cnt <= '0;
            b_stage_cnt <= '0;
            inc_evt     <= 1'b0;
        end else begin
            inc_evt <= time_hit || ack_hit;

            if (since_cut <= GAP_W'(`CC_MIN_MARK_GAP)) begin
                since_cut <= since_cut + 1'b1;
            end

            time_cnt <= time_hit ? '0 : time_cnt + 1'b1;
            if (ecn_valid) begin
                ack_cnt <= ack_hit ? '0 : ack_cnt + 1'b1;
            end
            if (time_hit && t_stage_cnt < STG_W'(`CC_F)) begin
                t_stage_cnt <= t_stage_cnt + 1'b1;
            end
            if (ack_hit && b_stage_cnt < STG_W'(`CC_F)) begin
                b_stage_cnt <= b_stage_cnt + 1'b1;
            end

            // decay once per quiet window, any mark restarts the window
            if (mark_seen) begin
                quiet_cnt <= '0;
            end else if (quiet_cnt == QUIET_W'(`CC_ALPHA_QUIET - 1)) begin
                quiet_cnt <= '0;
                alpha     <= alpha_decay;
            end else begin
                quiet_cnt <= quiet_cnt + 1'b1;
            end

            // recovery step, one cycle after the event flag
            if (inc_evt) begin
                target_rate <= rec_target;
                cur_rate    <= avg_sum[W:1];
            end

            // a counted mark overrides everything above
            if (mark_cut) begin
                target_rate <= cur_rate;
                cur_rate    <= cut_quot[W-1:0];
                alpha       <= alpha_up;
                since_cut   <= GAP_W'(1);
                time_cnt    <= '0;
                ack_cnt     <= '0;
                t_stage_cnt <= '0;
                b_stage_cnt <= '0;
                inc_evt     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== send_pacer.sv ====
`include "cc_defs.svh"
`default_nettype none

module send_pacer
    import cc_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  q_valid,
    output logic                  q_ready,
    input  dreq_t                 q_data,

    input  logic [`CC_RATE_W-1:0] cur_rate,

    output logic                  m_valid,
    input  logic                  m_ready,
    output dreq_t                 m_data
);

    logic [`CC_RATE_W-1:0] send_timer;
    logic                  held;
    logic                  gate_open;

    // once offered, keep the request up even if the gap grows meanwhile
    assign gate_open = (send_timer > cur_rate) || held;

    assign m_valid = q_valid && gate_open;
    assign q_ready = m_ready && gate_open;
    assign m_data  = q_data;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            send_timer <= '0;
            held       <= 1'b0;
        end else if (m_valid && m_ready) begin
            send_timer <= '0;
            held       <= 1'b0;
        end else begin
            if (send_timer != '1) begin
                send_timer <= send_timer + 1'b1;
            end
            held <= m_valid;
        end
    end

endmodule

`default_nettype wire

// ==== cc_queue.sv ====
`include "cc_defs.svh"
`default_nettype none

module cc_queue
    import cc_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  s_valid,
    output logic                  s_ready,
    input  dreq_t                 s_data,

    output logic                  m_valid,
    input  logic                  m_ready,
    output dreq_t                 m_data,

    input  logic                  ecn_valid,
    input  logic                  ecn_mark,

    output logic [`CC_RATE_W-1:0] cur_rate,
    output logic [`CC_RATE_W-1:0] target_rate,
    output logic [`CC_RATE_W-1:0] alpha,
    output cc_stage_t             stage
);

    // fifo head toward the pacer
    logic  q_valid;
    logic  q_ready;
    dreq_t q_data;

    req_fifo #(
        .DEPTH   (`CC_QDEPTH)
    ) req_fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (q_valid),
        .m_ready (q_ready),
        .m_data  (q_data)
    );

    dcqcn_rate_ctrl dcqcn_rate_ctrl_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .ecn_valid   (ecn_valid),
        .ecn_mark    (ecn_mark),
        .cur_rate    (cur_rate),
        .target_rate (target_rate),
        .alpha       (alpha),
        .stage       (stage)
    );

    send_pacer send_pacer_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .q_valid  (q_valid),
        .q_ready  (q_ready),
        .q_data   (q_data),
        .cur_rate (cur_rate),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_data   (m_data)
    );

endmodule

`default_nettype wire

// ==== cc_queue_properties.sv ====
`include "cc_defs.svh"
`default_nettype none

module cc_queue_properties
    import cc_pkg::*;
(
    input logic                  aclk,
    input logic                  aresetn,
    input logic                  s_ready,
    input logic                  m_valid,
    input logic                  m_ready,
    input dreq_t                 m_data,
    input logic [`CC_RATE_W-1:0] cur_rate,
    input logic [`CC_RATE_W-1:0] alpha
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // a stalled offer keeps its request
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else begin
            assert_fails++;
            $error("output request changed under back-pressure");
        end

    // queue empty and open right after reset
    assert property (@(posedge aclk) !aresetn |=> !m_valid && s_ready)
        else begin
            assert_fails++;
            $error("m_valid or s_ready wrong after reset");
        end

    assert property (@(posedge aclk)
        !aresetn |=> cur_rate == `CC_RATE_DEFAULT && alpha == `CC_ALPHA_ONE)
        else begin
            assert_fails++;
            $error("rate controller reset values wrong");
        end

endmodule

bind cc_queue cc_queue_properties cc_queue_properties_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_ready  (s_ready),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_data   (m_data),
    .cur_rate (cur_rate),
    .alpha    (alpha)
);

`default_nettype wire

// ==== tb_cc_queue.sv ====
`include "cc_defs.svh"
`default_nettype none

module tb_cc_queue
    import cc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STALL_LIMIT = 1000;
    localparam int DRAIN_LIMIT = 4000;

    logic                  aclk;
    logic                  aresetn;
    logic                  s_valid;
    logic                  s_ready;
    dreq_t                 s_data;
    logic                  m_valid;
    logic                  m_ready;
    dreq_t                 m_data;
    logic                  ecn_valid;
    logic                  ecn_mark;
    logic [`CC_RATE_W-1:0] cur_rate;
    logic [`CC_RATE_W-1:0] target_rate;
    logic [`CC_RATE_W-1:0] alpha;
    cc_stage_t             stage;

    // reference model of the rate controller
    logic [`CC_RATE_W-1:0] m_cur;
    logic [`CC_RATE_W-1:0] m_tgt;
    logic [`CC_RATE_W-1:0] m_alpha;
    int                    m_since;
    int                    m_quiet;
    int                    m_time;
    int                    m_acks;
    int                    m_tst;
    int                    m_bst;
    logic                  m_evt;

    dreq_t                 sent_q [$];
    dreq_t                 held_data;
    logic                  held_prev;
    int                    gap_cnt;
    logic [1:0]            rdy_mode;
    logic [1:0]            mode_now;
    int                    mismatches;
    int                    others;
    logic                  timed_out;

    cc_queue cc_queue_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data      (s_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .ecn_valid   (ecn_valid),
        .ecn_mark    (ecn_mark),
        .cur_rate    (cur_rate),
        .target_rate (target_rate),
        .alpha       (alpha),
        .stage       (stage)
    );

    always #5 aclk = ~aclk;

    function automatic cc_stage_t stage_of(input int t_cnt, input int b_cnt);
        if (t_cnt >= `CC_F && b_cnt >= `CC_F) begin
            return stage_hyper;
        end
        if (t_cnt >= `CC_F || b_cnt >= `CC_F) begin
            return stage_additive;
        end
        return stage_fast_recovery;
    endfunction

    task automatic check_rate(input string label, input logic [`CC_RATE_W-1:0] got,
                              input logic [`CC_RATE_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, label, got, exp);
        end
    endtask

    task automatic check_stage(input cc_stage_t got, input cc_stage_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: stage is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_req(input dreq_t got, input dreq_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: request %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string label, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, label, got, exp);
        end
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            others++;
            $display("malformed command line in stimulus file");
        end
    endtask

    // one clock of the controller rules, marks override recovery
    task automatic model_step(input logic ack, input logic mark);
        logic                  counted;
        logic                  t_ev;
        logic                  b_ev;
        logic [`CC_RATE_W-1:0] grown;
        counted = ack && mark && (m_since > `CC_MIN_MARK_GAP);
        t_ev    = (m_time == `CC_TIME_THRESH - 1);
        b_ev    = ack && (m_acks == `CC_BYTE_THRESH - 1);
        if (counted) begin
            m_tgt   = m_cur;
            m_cur   = 32'((64'(m_cur) * `CC_ALPHA_ONE) / (`CC_ALPHA_ONE - m_alpha / 2));
            m_alpha = 32'((64'(m_alpha) * (`CC_ALPHA_ONE - `CC_ALPHA_G)) / `CC_ALPHA_ONE
                          + `CC_ALPHA_G);
            m_since = 1;
            m_quiet = 0;
            m_time  = 0;
            m_acks  = 0;
            m_tst   = 0;
            m_bst   = 0;
            m_evt   = 1'b0;
        end else begin
            if (m_since <= `CC_MIN_MARK_GAP) begin
                m_since++;
            end
            if (m_evt) begin
                grown = (stage_of(m_tst, m_bst) == stage_additive) ? m_tgt + `CC_RAI : m_tgt;
                m_cur = 32'((64'(grown) + m_cur) / 2);
                m_tgt = grown;
            end
            m_evt  = t_ev || b_ev;
            m_time = t_ev ? 0 : m_time + 1;
            if (ack) begin
                m_acks = b_ev ? 0 : m_acks + 1;
            end
            if (t_ev && m_tst < `CC_F) begin
                m_tst++;
            end
            if (b_ev && m_bst < `CC_F) begin
                m_bst++;
            end
            if (ack && mark) begin
                m_quiet = 0;
            end else if (m_quiet == `CC_ALPHA_QUIET - 1) begin
                m_quiet = 0;
                m_alpha = 32'((64'(m_alpha) * (`CC_ALPHA_ONE - `CC_ALPHA_G)) / `CC_ALPHA_ONE);
            end else begin
                m_quiet++;
            end
        end
    endtask

    always @(posedge aclk) begin
        if (!aresetn) begin
            m_cur   = `CC_RATE_DEFAULT;
            m_tgt   = `CC_RATE_DEFAULT;
            m_alpha = `CC_ALPHA_ONE;
            m_since = 0;
            m_quiet = 0;
            m_time  = 0;
            m_acks  = 0;
            m_tst   = 0;
            m_bst   = 0;
            m_evt   = 1'b0;
        end else begin
            model_step(ecn_valid, ecn_mark);
        end
    end

    // sink ready pattern, mode is taken at the edge and applied 1 ns later
    initial begin
        void'($urandom(53111));
        forever begin
            @(posedge aclk);
            mode_now = rdy_mode;
            #1;
            case (mode_now)
                2'd1:    m_ready = ($urandom % 2) != 0;
                2'd2:    m_ready = 1'b0;
                default: m_ready = 1'b1;
            endcase
        end
    end

    // all DUT outputs are settled at the falling edge
    always @(negedge aclk) begin
        if (!aresetn) begin
            gap_cnt   = 0;
            held_prev = 1'b0;
        end else begin
            check_rate("cur_rate", cur_rate, m_cur);
            check_rate("target_rate", target_rate, m_tgt);
            check_rate("alpha", alpha, m_alpha);
            check_stage(stage, stage_of(m_tst, m_bst));
            // a full queue takes a word only when the head leaves in the same cycle
            check_flag("s_ready", s_ready,
                       (sent_q.size() < `CC_QDEPTH) || (m_valid && m_ready));
            if (held_prev) begin
                check_flag("m_valid under back-pressure", m_valid, 1'b1);
                check_req(m_data, held_data);
            end else if (m_valid && gap_cnt <= cur_rate) begin
                mismatches++;
                $display("Mismatch at %0t: request offered %0d cycles after last send, gap %0d",
                         $time, gap_cnt, cur_rate);
            end
            if (m_valid && m_ready) begin
                if (sent_q.size() == 0) begin
                    others++;
                    $display("output request seen with nothing pending at %0t", $time);
                end else begin
                    check_req(m_data, sent_q.pop_front());
                end
                gap_cnt = 0;
            end else begin
                gap_cnt++;
            end
            held_prev = m_valid && !m_ready;
            held_data = m_data;
            if (s_valid && s_ready) begin
                sent_q.push_back(s_data);
            end
        end
    end

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic send_req(input dreq_t req);
        int waited;
        waited  = 0;
        s_valid = 1'b1;
        s_data  = req;
        @(negedge aclk);
        while (!s_ready && !timed_out) begin
            if (waited == STALL_LIMIT) begin
                others++;
                timed_out = 1'b1;
                $display("timed out waiting for s_ready");
            end else begin
                waited++;
                @(negedge aclk);
            end
        end
        next_cycle();
        s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (sent_q.size() != 0 && !timed_out) begin
            if (waited == DRAIN_LIMIT) begin
                others++;
                timed_out = 1'b1;
                $display("timed out waiting for output request");
            end else begin
                waited++;
                @(posedge aclk);
            end
        end
    endtask

    task automatic run_command(input int fd, input logic [7:0] cmd);
        int          rc;
        int          ch;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        dreq_t       req;
        case (cmd)
            "#": begin
                ch = 0;
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end
            "X": begin
                rc = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                check_fields(rc, 4);
                @(negedge aclk);
                check_rate("cur_rate snapshot", cur_rate, f0);
                check_rate("target_rate snapshot", target_rate, f1);
                check_rate("alpha snapshot", alpha, f2);
                check_stage(stage, cc_stage_t'(f3[1:0]));
                next_cycle();
            end
            "R": begin
                rc = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                check_fields(rc, 4);
                req.opcode = f0[0];
                req.qpn    = f1[9:0];
                req.vaddr  = f2;
                req.len    = f3[20:0];
                send_req(req);
            end
            "E": begin
                rc = $fscanf(fd, "%h %h", f0, f1);
                check_fields(rc, 2);
                repeat (f1) begin
                    ecn_valid = 1'b1;
                    ecn_mark  = f0[0];
                    next_cycle();
                end
                ecn_valid = 1'b0;
                ecn_mark  = 1'b0;
            end
            "I": begin
                rc = $fscanf(fd, "%h", f0);
                check_fields(rc, 1);
                repeat (f0) next_cycle();
            end
            "B": begin
                rc = $fscanf(fd, "%h", f0);
                check_fields(rc, 1);
                rdy_mode = f0[1:0];
            end
            default: begin
                others++;
                $display("unknown command in stimulus file");
            end
        endcase
    endtask

    initial begin
        int         fd;
        int         assert_fails;
        logic [7:0] cmd;
        aclk       = 1'b0;
        aresetn    = 1'b0;
        s_valid    = 1'b0;
        s_data     = '0;
        m_ready    = 1'b1;
        ecn_valid  = 1'b0;
        ecn_mark   = 1'b0;
        rdy_mode   = 2'd0;
        mismatches = 0;
        others     = 0;
        timed_out  = 1'b0;
        repeat (4) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        fd = $fopen("cc_queue_input.txt", "r");
        if (fd == 0) begin
            others++;
            $display("could not open cc_queue_input.txt");
        end else begin
            while (!timed_out && $fscanf(fd, " %c", cmd) == 1) begin
                run_command(fd, cmd);
            end
            $fclose(fd);
            wait_drain();
        end
        assert_fails = cc_queue_i.cc_queue_properties_i.assert_fails;
        $display("errors: %0d mismatches, %0d other, %0d assertion", mismatches, others,
                 assert_fails);
        if (mismatches == 0 && others == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cc_queue_input.txt ====
# X cur target alpha stage | R opcode qpn vaddr len | E mark count | I cycles
# B ready mode (0 ready, 1 random, 2 stalled); every field is hex
X 28 28 100 0
R 1 03a 10000000 00400
R 0 011 2000f000 00080
E 1 1
I 46
E 1 1
E 1 1
E 0 3
I 64
B 2
R 1 101 30000000 01000
R 0 102 30001000 00800
R 1 103 30002000 1fffff
R 0 104 30003000 00001
R 1 105 30004000 00040
R 0 106 30005000 00200
R 1 107 30006000 0abcd
R 0 108 30007000 12345
I 14
B 1
R 1 109 40000000 00010
R 0 10a 40001000 00020
I 28
B 0
E 0 1e
I 300

// ==== sim.f ====
+incdir+.
cc_pkg.sv
req_fifo.sv
dcqcn_rate_ctrl.sv
send_pacer.sv
cc_queue.sv
cc_queue_properties.sv
tb_cc_queue.sv
